//--- Makefile
TOP := tb_decode

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

//--- hw/control_unit.sv
`default_nettype none

module control_unit
   import rv_decode_pkg::*;
(
   input  word_t      instr_i,
   input  word_t      imm_i,
   output alu_op_t    alu_op_o,
   output mem_op_t    mem_op_o,
   output wb_sel_t    wb_sel_o,
   output logic       alu_from_imm_o,
   output logic       alu_from_pc_o,
   output logic       reg_write_o,
   output logic       is_branch_o,
   output logic       is_jal_o,
   output logic       is_jalr_o,
   output csr_op_t    csr_op_o,
   output logic       csr_from_reg_o,
   output logic       exc_request_o,
   output logic       exc_ret_o,
   output logic       illegal_o,
   output exc_cause_t exc_cause_o
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7_b5;
   logic       bad;        // Encoding not recognized

   assign opcode    = instr_i[6:2];
   assign funct3    = instr_i[14:12];
   assign funct7_b5 = instr_i[30];

   always_comb begin
      alu_op_o       = ALU_ADD;
      mem_op_o       = MEM_NOP;
      wb_sel_o       = WB_ALU;
      alu_from_imm_o = 1'b0;
      alu_from_pc_o  = 1'b0;
      reg_write_o    = 1'b0;
      is_branch_o    = 1'b0;
      is_jal_o       = 1'b0;
      is_jalr_o      = 1'b0;
      csr_op_o       = CSR_NOP;
      csr_from_reg_o = 1'b0;
      exc_request_o  = 1'b0;
      exc_ret_o      = 1'b0;
      illegal_o      = 1'b0;
      exc_cause_o    = '0;
      bad            = (instr_i[1:0] != 2'b11);  // No compressed forms

      case (opcode)
         OP_LOAD: begin
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
            case (funct3)
               3'b000:  mem_op_o = MEM_LB;
               3'b001:  mem_op_o = MEM_LH;
               3'b010:  mem_op_o = MEM_LW;
               3'b100:  mem_op_o = MEM_LBU;
               3'b101:  mem_op_o = MEM_LHU;
               default: bad = 1'b1;
            endcase
         end
         OP_FENCE: begin
            // Treated as a no-op
         end
         OP_IMM: begin
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
            case (funct3)
               3'b000:  alu_op_o = ALU_ADD;
               3'b001:  alu_op_o = ALU_SLL;
               3'b010:  alu_op_o = ALU_SLT;
               3'b011:  alu_op_o = ALU_SLTU;
               3'b100:  alu_op_o = ALU_XOR;
               3'b101:  alu_op_o = imm_i[10] ? ALU_SRA : ALU_SRL;
               3'b110:  alu_op_o = ALU_OR;
               default: alu_op_o = ALU_AND;
            endcase
         end
         OP_AUIPC: begin
            alu_from_pc_o  = 1'b1;
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
         end
         OP_STORE: begin
            alu_from_imm_o = 1'b1;
            case (funct3)
               3'b000:  mem_op_o = MEM_SB;
               3'b001:  mem_op_o = MEM_SH;
               3'b010:  mem_op_o = MEM_SW;
               default: bad = 1'b1;
            endcase
         end
         OP_REG: begin
            reg_write_o = 1'b1;
            case (funct3)
               3'b000:  alu_op_o = funct7_b5 ? ALU_SUB : ALU_ADD;
               3'b001:  alu_op_o = ALU_SLL;
               3'b010:  alu_op_o = ALU_SLT;
               3'b011:  alu_op_o = ALU_SLTU;
               3'b100:  alu_op_o = ALU_XOR;
               3'b101:  alu_op_o = funct7_b5 ? ALU_SRA : ALU_SRL;
               3'b110:  alu_op_o = ALU_OR;
               default: alu_op_o = ALU_AND;
            endcase
         end
         OP_LUI: begin
            wb_sel_o       = WB_IMM;
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
         end
         OP_BRANCH: begin
            is_branch_o = 1'b1;
            case (funct3)
               3'b000:  alu_op_o = ALU_CE;
               3'b001:  alu_op_o = ALU_CNE;
               3'b100:  alu_op_o = ALU_SLT;
               3'b101:  alu_op_o = ALU_CGE;
               3'b110:  alu_op_o = ALU_SLTU;
               3'b111:  alu_op_o = ALU_CGEU;
               default: bad = 1'b1;
            endcase
         end
         OP_JALR: begin
            wb_sel_o       = WB_PC4;
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
            is_jalr_o      = 1'b1;
         end
         OP_JAL: begin
            wb_sel_o       = WB_PC4;
            alu_from_pc_o  = 1'b1;
            alu_from_imm_o = 1'b1;
            reg_write_o    = 1'b1;
            is_jal_o       = 1'b1;
         end
         OP_SYSTEM: begin
            wb_sel_o = WB_CSR;
            if (funct3 == 3'b000) begin
               case (imm_i[11:0])
                  SYS_ECALL: begin
                     exc_request_o = 1'b1;
                     exc_cause_o   = CAUSE_ECALL;
                  end
                  SYS_EBREAK: begin
                     exc_request_o = 1'b1;
                     exc_cause_o   = CAUSE_BREAK;
                  end
                  SYS_MRET: exc_ret_o = 1'b1;
                  SYS_WFI:  ;  // No stall, plain no-op
                  default:  bad = 1'b1;
               endcase
            end else if (funct3 == 3'b100) begin
               bad = 1'b1;
            end else begin
               // funct3[2] picks the zimm forms
               reg_write_o    = 1'b1;
               csr_from_reg_o = !funct3[2];
               case (funct3[1:0])
                  2'b01:   csr_op_o = CSR_RW;
                  2'b10:   csr_op_o = CSR_RS;
                  default: csr_op_o = CSR_RC;
               endcase
            end
         end
         default: begin
            bad = 1'b1;
         end
      endcase

      // Illegal wins over everything decoded above
      if (bad) begin
         alu_op_o       = ALU_ADD;
         mem_op_o       = MEM_NOP;
         wb_sel_o       = WB_ALU;
         alu_from_imm_o = 1'b0;
         alu_from_pc_o  = 1'b0;
         reg_write_o    = 1'b0;
         is_branch_o    = 1'b0;
         is_jal_o       = 1'b0;
         is_jalr_o      = 1'b0;
         csr_op_o       = CSR_NOP;
         csr_from_reg_o = 1'b0;
         exc_ret_o      = 1'b0;
         exc_request_o  = 1'b1;
         illegal_o      = 1'b1;
         exc_cause_o    = CAUSE_ILLEGAL;
      end
   end

endmodule

`default_nettype wire

//--- hw/decode_reg.sv
`default_nettype none

module decode_reg
   import rv_decode_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,
   input  alu_op_t    alu_op_i,
   input  mem_op_t    mem_op_i,
   input  wb_sel_t    wb_sel_i,
   input  csr_op_t    csr_op_i,
   input  logic       alu_from_imm_i,
   input  logic       alu_from_pc_i,
   input  logic       reg_write_i,
   input  logic       is_branch_i,
   input  logic       is_jal_i,
   input  logic       is_jalr_i,
   input  logic       csr_from_reg_i,
   input  logic       exc_request_i,
   input  logic       exc_ret_i,
   input  logic       illegal_i,
   input  exc_cause_t exc_cause_i,
   input  word_t      imm_i,
   input  word_t      pc_i,
   input  reg_idx_t   rd_i,
   input  reg_idx_t   rs1_i,
   input  reg_idx_t   rs2_i,
   output logic       out_valid_o,
   input  logic       out_ready_i,
   output alu_op_t    alu_op_o,
   output mem_op_t    mem_op_o,
   output wb_sel_t    wb_sel_o,
   output csr_op_t    csr_op_o,
   output logic       alu_from_imm_o,
   output logic       alu_from_pc_o,
   output logic       reg_write_o,
   output logic       is_branch_o,
   output logic       is_jal_o,
   output logic       is_jalr_o,
   output logic       csr_from_reg_o,
   output logic       exc_request_o,
   output logic       exc_ret_o,
   output logic       illegal_o,
   output exc_cause_t exc_cause_o,
   output word_t      imm_o,
   output word_t      pc_o,
   output reg_idx_t   rd_o,
   output reg_idx_t   rs1_o,
   output reg_idx_t   rs2_o
);

   logic [ENTRY_W-1:0] in_entry;
   logic [ENTRY_W-1:0] main_q;     // Oldest, drives the outputs
   logic [ENTRY_W-1:0] skid_q;
   logic               main_v_q;
   logic               skid_v_q;
   logic               main_v_n;
   logic               skid_v_n;
   logic               in_ready_q;
   logic               push;
   logic               pop;
   logic               load_main;
   logic               load_skid;
   logic               main_from_skid;

   logic [$bits(alu_op_t)-1:0] alu_op_bits;
   logic [$bits(mem_op_t)-1:0] mem_op_bits;
   logic [$bits(wb_sel_t)-1:0] wb_sel_bits;
   logic [$bits(csr_op_t)-1:0] csr_op_bits;

   assign in_entry = {alu_op_i, mem_op_i, wb_sel_i, csr_op_i, alu_from_imm_i, alu_from_pc_i,
                      reg_write_i, is_branch_i, is_jal_i, is_jalr_i, csr_from_reg_i,
                      exc_request_i, exc_ret_i, illegal_i, exc_cause_i, imm_i, pc_i,
                      rd_i, rs1_i, rs2_i};

   assign {alu_op_bits, mem_op_bits, wb_sel_bits, csr_op_bits, alu_from_imm_o, alu_from_pc_o,
           reg_write_o, is_branch_o, is_jal_o, is_jalr_o, csr_from_reg_o,
           exc_request_o, exc_ret_o, illegal_o, exc_cause_o, imm_o, pc_o,
           rd_o, rs1_o, rs2_o} = main_q;

   assign alu_op_o = alu_op_t'(alu_op_bits);
   assign mem_op_o = mem_op_t'(mem_op_bits);
   assign wb_sel_o = wb_sel_t'(wb_sel_bits);
   assign csr_op_o = csr_op_t'(csr_op_bits);

   assign in_ready_o  = in_ready_q;
   assign out_valid_o = main_v_q;
   assign push        = in_valid_i && in_ready_q;
   assign pop         = main_v_q && out_ready_i;

   always_comb begin
      main_v_n       = main_v_q;
      skid_v_n       = skid_v_q;
      load_main      = 1'b0;
      load_skid      = 1'b0;
      main_from_skid = 1'b0;
      if (pop) begin
         if (skid_v_q) begin
            main_from_skid = 1'b1;  // Skid moves up, new word may refill it
            skid_v_n       = push;
            load_skid      = push;
         end else begin
            main_v_n  = push;
            load_main = push;
         end
      end else if (push) begin
         if (main_v_q) begin
            skid_v_n  = 1'b1;
            load_skid = 1'b1;
         end else begin
            main_v_n  = 1'b1;
            load_main = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         main_v_q   <= 1'b0;
         skid_v_q   <= 1'b0;
         in_ready_q <= 1'b1;
      end else begin
         main_v_q   <= main_v_n;
         skid_v_q   <= skid_v_n;
         in_ready_q <= !(main_v_n && skid_v_n);  // Ready from next state, not from out_ready_i
      end
   end

   always_ff @(posedge clk) begin
      if (main_from_skid) begin
         main_q <= skid_q;
      end else if (load_main) begin
         main_q <= in_entry;
      end
      if (load_skid) begin
         skid_q <= in_entry;
      end
   end

endmodule

`default_nettype wire

//--- hw/decode_top.sv
`default_nettype none

module decode_top
   import rv_decode_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,
   input  word_t      instr_i,
   input  word_t      pc_i,
   output logic       out_valid_o,
   input  logic       out_ready_i,
   output alu_op_t    alu_op_o,
   output mem_op_t    mem_op_o,
   output wb_sel_t    wb_sel_o,
   output csr_op_t    csr_op_o,
   output logic       alu_from_imm_o,
   output logic       alu_from_pc_o,
   output logic       reg_write_o,
   output logic       is_branch_o,
   output logic       is_jal_o,
   output logic       is_jalr_o,
   output logic       csr_from_reg_o,
   output logic       exc_request_o,
   output logic       exc_ret_o,
   output logic       illegal_o,
   output exc_cause_t exc_cause_o,
   output word_t      imm_o,
   output word_t      pc_o,
   output reg_idx_t   rd_o,
   output reg_idx_t   rs1_o,
   output reg_idx_t   rs2_o
);

   word_t      imm;
   alu_op_t    alu_op;
   mem_op_t    mem_op;
   wb_sel_t    wb_sel;
   csr_op_t    csr_op;
   logic       alu_from_imm;
   logic       alu_from_pc;
   logic       reg_write;
   logic       is_branch;
   logic       is_jal;
   logic       is_jalr;
   logic       csr_from_reg;
   logic       exc_request;
   logic       exc_ret;
   logic       illegal;
   exc_cause_t exc_cause;

   imm_gen u_imm_gen (
      .instr_i (instr_i),
      .imm_o   (imm)
   );

   control_unit u_control_unit (
      .instr_i        (instr_i),
      .imm_i          (imm),
      .alu_op_o       (alu_op),
      .mem_op_o       (mem_op),
      .wb_sel_o       (wb_sel),
      .alu_from_imm_o (alu_from_imm),
      .alu_from_pc_o  (alu_from_pc),
      .reg_write_o    (reg_write),
      .is_branch_o    (is_branch),
      .is_jal_o       (is_jal),
      .is_jalr_o      (is_jalr),
      .csr_op_o       (csr_op),
      .csr_from_reg_o (csr_from_reg),
      .exc_request_o  (exc_request),
      .exc_ret_o      (exc_ret),
      .illegal_o      (illegal),
      .exc_cause_o    (exc_cause)
   );

   // Register fields taken straight from the instruction word
   decode_reg u_decode_reg (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .alu_op_i       (alu_op),
      .mem_op_i       (mem_op),
      .wb_sel_i       (wb_sel),
      .csr_op_i       (csr_op),
      .alu_from_imm_i (alu_from_imm),
      .alu_from_pc_i  (alu_from_pc),
      .reg_write_i    (reg_write),
      .is_branch_i    (is_branch),
      .is_jal_i       (is_jal),
      .is_jalr_i      (is_jalr),
      .csr_from_reg_i (csr_from_reg),
      .exc_request_i  (exc_request),
      .exc_ret_i      (exc_ret),
      .illegal_i      (illegal),
      .exc_cause_i    (exc_cause),
      .imm_i          (imm),
      .pc_i           (pc_i),
      .rd_i           (instr_i[11:7]),
      .rs1_i          (instr_i[19:15]),
      .rs2_i          (instr_i[24:20]),
      .out_valid_o    (out_valid_o),
      .out_ready_i    (out_ready_i),
      .alu_op_o       (alu_op_o),
      .mem_op_o       (mem_op_o),
      .wb_sel_o       (wb_sel_o),
      .csr_op_o       (csr_op_o),
      .alu_from_imm_o (alu_from_imm_o),
      .alu_from_pc_o  (alu_from_pc_o),
      .reg_write_o    (reg_write_o),
      .is_branch_o    (is_branch_o),
      .is_jal_o       (is_jal_o),
      .is_jalr_o      (is_jalr_o),
      .csr_from_reg_o (csr_from_reg_o),
      .exc_request_o  (exc_request_o),
      .exc_ret_o      (exc_ret_o),
      .illegal_o      (illegal_o),
      .exc_cause_o    (exc_cause_o),
      .imm_o          (imm_o),
      .pc_o           (pc_o),
      .rd_o           (rd_o),
      .rs1_o          (rs1_o),
      .rs2_o          (rs2_o)
   );

endmodule

`default_nettype wire

//--- hw/imm_gen.sv
`default_nettype none

module imm_gen
   import rv_decode_pkg::*;
(
   input  word_t instr_i,
   output word_t imm_o
);

   opcode_t opcode;

   assign opcode = instr_i[6:2];

   always_comb begin
      case (opcode)
         // I format, SYSTEM uses imm[11:0] as function select
         OP_LOAD,
         OP_FENCE,
         OP_IMM,
         OP_JALR,
         OP_SYSTEM: begin
            imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
         end
         OP_STORE: begin
            imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         end
         OP_BRANCH: begin
            imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
         end
         OP_LUI,
         OP_AUIPC: begin
            imm_o = {instr_i[31:12], 12'b0};
         end
         OP_JAL: begin
            imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                     instr_i[20], instr_i[30:21], 1'b0};
         end
         default: begin
            imm_o = '0;  // R-type and unknown
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hw/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

   typedef logic [31:0] word_t;     // Instruction, PC or immediate
   typedef logic [4:0]  reg_idx_t;
   typedef logic [4:0]  opcode_t;   // instr[6:2]
   typedef logic [3:0]  exc_cause_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_CE,    // Branch compares
      ALU_CNE,
      ALU_CGE,
      ALU_CGEU
   } alu_op_t;

   typedef enum logic [3:0] {
      MEM_NOP,
      MEM_LB,
      MEM_LH,
      MEM_LW,
      MEM_LBU,
      MEM_LHU,
      MEM_SB,
      MEM_SH,
      MEM_SW
   } mem_op_t;

   // Write-back source, loads go through WB_ALU with mem_op set
   typedef enum logic [1:0] {
      WB_ALU,
      WB_PC4,
      WB_CSR,
      WB_IMM
   } wb_sel_t;

   typedef enum logic [1:0] {
      CSR_NOP,
      CSR_RW,
      CSR_RS,
      CSR_RC
   } csr_op_t;

   localparam opcode_t OP_LOAD   = 5'b00000;
   localparam opcode_t OP_FENCE  = 5'b00011;
   localparam opcode_t OP_IMM    = 5'b00100;
   localparam opcode_t OP_AUIPC  = 5'b00101;
   localparam opcode_t OP_STORE  = 5'b01000;
   localparam opcode_t OP_REG    = 5'b01100;
   localparam opcode_t OP_LUI    = 5'b01101;
   localparam opcode_t OP_BRANCH = 5'b11000;
   localparam opcode_t OP_JALR   = 5'b11001;
   localparam opcode_t OP_JAL    = 5'b11011;
   localparam opcode_t OP_SYSTEM = 5'b11100;

   localparam exc_cause_t CAUSE_ILLEGAL = 4'd2;
   localparam exc_cause_t CAUSE_BREAK   = 4'd3;
   localparam exc_cause_t CAUSE_ECALL   = 4'd11;

   // SYSTEM funct3 0, low 12 immediate bits
   localparam logic [11:0] SYS_ECALL  = 12'h000;
   localparam logic [11:0] SYS_EBREAK = 12'h001;
   localparam logic [11:0] SYS_MRET   = 12'h302;
   localparam logic [11:0] SYS_WFI    = 12'h105;

   // One decoded entry in the output register: control word, imm, pc, rd, rs1, rs2
   localparam int ENTRY_W = $bits(alu_op_t) + $bits(mem_op_t) + $bits(wb_sel_t)
                          + $bits(csr_op_t) + 10 + $bits(exc_cause_t)
                          + 2 * $bits(word_t) + 3 * $bits(reg_idx_t);

endpackage

`default_nettype wire

//--- sim/decode_checker.sv
`default_nettype none

module decode_checker
   import rv_decode_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       in_valid_i,
   input  logic       in_ready_o,
   input  word_t      instr_i,
   input  word_t      pc_i,
   input  logic       out_valid_o,
   input  logic       out_ready_i,
   input  alu_op_t    alu_op_o,
   input  mem_op_t    mem_op_o,
   input  wb_sel_t    wb_sel_o,
   input  csr_op_t    csr_op_o,
   input  logic       alu_from_imm_o,
   input  logic       alu_from_pc_o,
   input  logic       reg_write_o,
   input  logic       is_branch_o,
   input  logic       is_jal_o,
   input  logic       is_jalr_o,
   input  logic       csr_from_reg_o,
   input  logic       exc_request_o,
   input  logic       exc_ret_o,
   input  logic       illegal_o,
   input  exc_cause_t exc_cause_o,
   input  word_t      imm_o,
   input  word_t      pc_o,
   input  reg_idx_t   rd_o,
   input  reg_idx_t   rs1_o,
   input  reg_idx_t   rs2_o,
   output int         err_count_o,
   output int         in_count_o,
   output int         out_count_o
);

   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic [3:0] alu_op;
      logic [3:0] mem_op;
      logic [1:0] wb_sel;
      logic [1:0] csr_op;
      logic       alu_from_imm;
      logic       alu_from_pc;
      logic       reg_write;
      logic       is_branch;
      logic       is_jal;
      logic       is_jalr;
      logic       csr_from_reg;
      logic       exc_request;
      logic       exc_ret;
      logic       illegal;
      logic [3:0] exc_cause;
      word_t      imm;
      word_t      pc;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
   } item_t;

   item_t exp_q[$];   // Accepted but not yet seen at the output
   item_t act;
   item_t held;
   logic  held_v = 1'b0;
   int    errors = 0;
   int    n_in = 0;
   int    n_out = 0;

   assign act = {alu_op_o, mem_op_o, wb_sel_o, csr_op_o, alu_from_imm_o, alu_from_pc_o,
                 reg_write_o, is_branch_o, is_jal_o, is_jalr_o, csr_from_reg_o,
                 exc_request_o, exc_ret_o, illegal_o, exc_cause_o, imm_o, pc_o,
                 rd_o, rs1_o, rs2_o};

   assign err_count_o = errors;
   assign in_count_o  = n_in;
   assign out_count_o = n_out;

   // alt picks SUB or SRA in the register and immediate forms
   function automatic logic [3:0] arith_op(logic [2:0] f3, logic alt);
      case (f3)
         3'd0:    return alt ? ALU_SUB : ALU_ADD;
         3'd1:    return ALU_SLL;
         3'd2:    return ALU_SLT;
         3'd3:    return ALU_SLTU;
         3'd4:    return ALU_XOR;
         3'd5:    return alt ? ALU_SRA : ALU_SRL;
         3'd6:    return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   function automatic item_t decode_model(word_t instr, word_t pc);
      item_t       e;
      opcode_t     op;
      logic [2:0]  f3;
      logic [11:0] sys;
      logic        bad;
      op  = instr[6:2];
      f3  = instr[14:12];
      sys = instr[31:20];
      e   = '0;   // Zero is ADD, MEM_NOP, WB_ALU and CSR_NOP
      bad = (instr[1:0] != 2'b11);
      case (op)
         OP_LOAD: begin
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
            case (f3)
               3'd0:    e.mem_op = MEM_LB;
               3'd1:    e.mem_op = MEM_LH;
               3'd2:    e.mem_op = MEM_LW;
               3'd4:    e.mem_op = MEM_LBU;
               3'd5:    e.mem_op = MEM_LHU;
               default: bad = 1'b1;
            endcase
         end
         OP_FENCE: begin
         end
         OP_IMM: begin
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
            e.alu_op       = arith_op(f3, (f3 == 3'd5) && instr[30]);  // imm bit 10
         end
         OP_AUIPC: begin
            e.alu_from_pc  = 1'b1;
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
         end
         OP_STORE: begin
            e.alu_from_imm = 1'b1;
            case (f3)
               3'd0:    e.mem_op = MEM_SB;
               3'd1:    e.mem_op = MEM_SH;
               3'd2:    e.mem_op = MEM_SW;
               default: bad = 1'b1;
            endcase
         end
         OP_REG: begin
            e.reg_write = 1'b1;
            e.alu_op    = arith_op(f3, instr[30]);
         end
         OP_LUI: begin
            e.wb_sel       = WB_IMM;
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
         end
         OP_BRANCH: begin
            e.is_branch = 1'b1;
            case (f3)
               3'd0:    e.alu_op = ALU_CE;
               3'd1:    e.alu_op = ALU_CNE;
               3'd4:    e.alu_op = ALU_SLT;
               3'd5:    e.alu_op = ALU_CGE;
               3'd6:    e.alu_op = ALU_SLTU;
               3'd7:    e.alu_op = ALU_CGEU;
               default: bad = 1'b1;
            endcase
         end
         OP_JALR: begin
            e.wb_sel       = WB_PC4;
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
            e.is_jalr      = 1'b1;
         end
         OP_JAL: begin
            e.wb_sel       = WB_PC4;
            e.alu_from_pc  = 1'b1;
            e.alu_from_imm = 1'b1;
            e.reg_write    = 1'b1;
            e.is_jal       = 1'b1;
         end
         OP_SYSTEM: begin
            e.wb_sel = WB_CSR;
            if (f3 == 3'd0) begin
               if (sys == SYS_ECALL) begin
                  e.exc_request = 1'b1;
                  e.exc_cause   = CAUSE_ECALL;
               end else if (sys == SYS_EBREAK) begin
                  e.exc_request = 1'b1;
                  e.exc_cause   = CAUSE_BREAK;
               end else if (sys == SYS_MRET) begin
                  e.exc_ret = 1'b1;
               end else if (sys != SYS_WFI) begin
                  bad = 1'b1;
               end
            end else if (f3 == 3'd4) begin
               bad = 1'b1;
            end else begin
               e.reg_write    = 1'b1;
               e.csr_from_reg = !f3[2];
               e.csr_op = (f3[1:0] == 2'd1) ? CSR_RW : (f3[1:0] == 2'd2) ? CSR_RS : CSR_RC;
            end
         end
         default: bad = 1'b1;
      endcase
      if (bad) begin
         e             = '0;
         e.exc_request = 1'b1;
         e.illegal     = 1'b1;
         e.exc_cause   = CAUSE_ILLEGAL;
      end
      // Immediate, PC and register fields pass even for illegal words
      case (op)
         OP_LOAD, OP_FENCE, OP_IMM, OP_JALR, OP_SYSTEM: begin
            e.imm = {{20{instr[31]}}, instr[31:20]};
         end
         OP_STORE: e.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         OP_BRANCH: begin
            e.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         end
         OP_LUI, OP_AUIPC: e.imm = {instr[31:12], 12'h000};
         OP_JAL: begin
            e.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         default: e.imm = '0;
      endcase
      e.pc  = pc;
      e.rd  = instr[11:7];
      e.rs1 = instr[19:15];
      e.rs2 = instr[24:20];
      return e;
   endfunction

   task automatic check_field(string name, logic [31:0] exp_v, logic [31:0] act_v, word_t pc);
      if (exp_v !== act_v) begin
         errors++;
         $display("FAILED %s: expected 0x%0h, actual 0x%0h (pc 0x%08h)", name, exp_v, act_v, pc);
      end
   endtask

   task automatic check_item(item_t e, item_t a);
      check_field("alu_op_o", 32'(e.alu_op), 32'(a.alu_op), e.pc);
      check_field("mem_op_o", 32'(e.mem_op), 32'(a.mem_op), e.pc);
      check_field("wb_sel_o", 32'(e.wb_sel), 32'(a.wb_sel), e.pc);
      check_field("csr_op_o", 32'(e.csr_op), 32'(a.csr_op), e.pc);
      check_field("alu_from_imm_o", 32'(e.alu_from_imm), 32'(a.alu_from_imm), e.pc);
      check_field("alu_from_pc_o", 32'(e.alu_from_pc), 32'(a.alu_from_pc), e.pc);
      check_field("reg_write_o", 32'(e.reg_write), 32'(a.reg_write), e.pc);
      check_field("is_branch_o", 32'(e.is_branch), 32'(a.is_branch), e.pc);
      check_field("is_jal_o", 32'(e.is_jal), 32'(a.is_jal), e.pc);
      check_field("is_jalr_o", 32'(e.is_jalr), 32'(a.is_jalr), e.pc);
      check_field("csr_from_reg_o", 32'(e.csr_from_reg), 32'(a.csr_from_reg), e.pc);
      check_field("exc_request_o", 32'(e.exc_request), 32'(a.exc_request), e.pc);
      check_field("exc_ret_o", 32'(e.exc_ret), 32'(a.exc_ret), e.pc);
      check_field("illegal_o", 32'(e.illegal), 32'(a.illegal), e.pc);
      check_field("exc_cause_o", 32'(e.exc_cause), 32'(a.exc_cause), e.pc);
      check_field("imm_o", e.imm, a.imm, e.pc);
      check_field("pc_o", e.pc, a.pc, e.pc);  // Catches loss and reordering
      check_field("rd_o", 32'(e.rd), 32'(a.rd), e.pc);
      check_field("rs1_o", 32'(e.rs1), 32'(a.rs1), e.pc);
      check_field("rs2_o", 32'(e.rs2), 32'(a.rs2), e.pc);
   endtask

   // Sampled mid-cycle where the handshake has settled for the coming edge
   always @(negedge clk) begin
      // Entries held follow from the transfers at earlier edges
      if (out_valid_o !== ((n_in - n_out) != 0) || in_ready_o !== ((n_in - n_out) < 2)) begin
         errors++;
         $display("Handshake wrong with %0d entries held: out_valid_o=%0b in_ready_o=%0b",
                  n_in - n_out, out_valid_o, in_ready_o);
      end
      if (held_v && (!out_valid_o || act != held)) begin
         errors++;
         $display("Outputs changed while out_valid_o was high and out_ready_i was low");
      end
      // Pop before push since the word taken now was accepted earlier
      if (arst_n_i && out_valid_o && out_ready_i) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Output transfer with no accepted instruction pending");
         end else begin
            check_item(exp_q.pop_front(), act);
         end
         n_out++;
      end
      if (arst_n_i && in_valid_i && in_ready_o) begin
         exp_q.push_back(decode_model(instr_i, pc_i));
         n_in++;
      end
      held_v = arst_n_i && out_valid_o && !out_ready_i;
      held   = act;
   end

endmodule

`default_nettype wire

//--- sim/tb_decode.sv
`default_nettype none

module tb_decode
   import rv_decode_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 20;
   localparam int N_INSTR    = 2000;
   localparam int TIMEOUT_NS = N_INSTR * 20 * CLK_PERIOD;

   localparam opcode_t LEGAL_OPS [11] = '{OP_LOAD, OP_FENCE, OP_IMM, OP_AUIPC, OP_STORE,
                                          OP_REG, OP_LUI, OP_BRANCH, OP_JALR, OP_JAL,
                                          OP_SYSTEM};

   logic       clk;
   logic       arst_n_i;
   logic       in_valid_i;
   logic       in_ready_o;
   word_t      instr_i;
   word_t      pc_i;
   logic       out_valid_o;
   logic       out_ready_i;
   alu_op_t    alu_op_o;
   mem_op_t    mem_op_o;
   wb_sel_t    wb_sel_o;
   csr_op_t    csr_op_o;
   logic       alu_from_imm_o;
   logic       alu_from_pc_o;
   logic       reg_write_o;
   logic       is_branch_o;
   logic       is_jal_o;
   logic       is_jalr_o;
   logic       csr_from_reg_o;
   logic       exc_request_o;
   logic       exc_ret_o;
   logic       illegal_o;
   exc_cause_t exc_cause_o;
   word_t      imm_o;
   word_t      pc_o;
   reg_idx_t   rd_o;
   reg_idx_t   rs1_o;
   reg_idx_t   rs2_o;
   int         err_count_o;
   int         in_count_o;
   int         out_count_o;

   logic [31:0] lfsr = 32'h95e44275;

   decode_top u_decode_top (.*);

   decode_checker u_decode_checker (.*);

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois form
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic word_t make_instr();
      word_t      w;
      logic [3:0] idx;
      logic [2:0] sel;
      w = take_bits(32);
      if (take_bits(2) != 0) begin
         idx    = 4'(take_bits(4) % 32'd11);
         w[6:0] = {LEGAL_OPS[idx], 2'b11};
         if (w[6:2] == OP_SYSTEM && take_bits(1) != 0) begin
            w[14:12] = 3'b000;
            sel      = 3'(take_bits(3));
            case (sel)
               3'd0:    w[31:20] = SYS_ECALL;
               3'd1:    w[31:20] = SYS_EBREAK;
               3'd2:    w[31:20] = SYS_MRET;
               3'd3:    w[31:20] = SYS_WFI;
               default: ;  // Random system immediate
            endcase
         end
      end
      return w;
   endfunction

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      int   sent;
      int   count_err;
      logic fire;
      sent        = 0;
      count_err   = 0;
      arst_n_i    = 1'b0;
      in_valid_i  = 1'b0;
      instr_i     = '0;
      pc_i        = 32'h8000_0000;
      out_ready_i = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      arst_n_i = 1'b1;
      while (sent < N_INSTR) begin
         @(negedge clk);
         fire = in_valid_i && in_ready_o;
         @(posedge clk);
         #2;
         if (fire) begin
            sent++;
         end
         out_ready_i = (take_bits(1) != 0);
         // Hold valid and data until accepted
         if (!in_valid_i || fire) begin
            in_valid_i = (sent < N_INSTR) && (take_bits(2) != 0);
            if (in_valid_i) begin
               instr_i = make_instr();
               pc_i    = pc_i + 32'd4;
            end
         end
      end
      out_ready_i = 1'b1;
      wait (out_count_o == N_INSTR);
      repeat (4) @(posedge clk);
      if (in_count_o != out_count_o) begin
         $display("Count mismatch: %0d accepted but %0d decoded", in_count_o, out_count_o);
         count_err = 1;
      end
      $display("Errors: %0d, accepted: %0d, decoded: %0d",
               err_count_o + count_err, in_count_o, out_count_o);
      if (err_count_o + count_err == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns with %0d of %0d instructions decoded",
               TIMEOUT_NS, out_count_o, N_INSTR);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
hw/rv_decode_pkg.sv
hw/imm_gen.sv
hw/control_unit.sv
hw/decode_reg.sv
hw/decode_top.sv
sim/decode_checker.sv
sim/tb_decode.sv
